/* verilog/dma_pkg.sv */
/*
 * DMA command and memory beat definitions
 * Command word layout, opcodes and the 32-bit memory data path used
 * between the scan-out sequencer and the DMA read engine
 */
package dma_pkg;

    localparam int MEM_ADDR_BITS = 32;
    localparam int MEM_DATA_BITS = 32;

    // Bytes per memory beat, every burst is a 4-byte INCR burst
    localparam int MEM_WORD_BYTES = MEM_DATA_BITS / 8;

    typedef logic [MEM_ADDR_BITS-1:0] mem_addr_t;
    typedef logic [MEM_DATA_BITS-1:0] mem_word_t;

    // Header opcodes, anything else is consumed and dropped
    localparam logic [1:0] DMA_OP_MEM_TO_STREAM = 2'd1;

    // Address modes
    localparam logic [1:0] DMA_MODE_INCR = 2'd3;

    // One command stream word
    // The header word comes first (tlast low), the base address second
    typedef union packed {
        struct packed {
            logic [1:0]  op;
            logic [1:0]  mode;
            logic [27:0] byte_count;
        } hdr;
        mem_addr_t addr;
    } cmd_word_u;

endpackage

/* verilog/disp_pkg.sv */
/*
 * Display pixel definitions
 * RGB565 pixel format of the display stream and how pixels pack
 * into framebuffer memory words
 */
package disp_pkg;

    // RGB565, red in the top five bits
    localparam int PIXEL_BITS = 16;

    // Pixels per 32-bit memory word
    // Lower address pixel sits in the low half
    localparam int PIXELS_PER_WORD = 2;

    typedef logic [PIXEL_BITS-1:0] pixel_t;

endpackage

/* verilog/fb_scanout_ctrl.sv */
/*
 * Framebuffer scan-out sequencer
 * Turns a swap_fb request into a two-word DMA command (header, then base
 * address) and reports acceptance of the command on fb_swapped
 */
`timescale 1ns/1ns

module fb_scanout_ctrl #(
    parameter int DISPLAY_SIZE_IN_BYTES = 320 * 480 * 2
) (
    input  logic               aclk,
    input  logic               resetn,

    input  logic               swap_fb,
    input  dma_pkg::mem_addr_t fb_addr,
    output logic               fb_swapped,

    // Command stream to the DMA engine
    output logic               cmd_tvalid,
    input  logic               cmd_tready,
    output logic               cmd_tlast,
    output dma_pkg::cmd_word_u cmd_tdata
);
    import dma_pkg::*;

    // Idle, header presented, address presented
    localparam logic [1:0] ST_CMD  = 2'd0;
    localparam logic [1:0] ST_ADDR = 2'd1;
    localparam logic [1:0] ST_WAIT = 2'd2;

    localparam logic [27:0] FRAME_BYTES = 28'(DISPLAY_SIZE_IN_BYTES);

    logic [1:0] state;
    logic       cmd_hs;

    assign cmd_hs = cmd_tvalid && cmd_tready;

    always_ff @(posedge aclk)
    begin
        if (!resetn)
        begin
            state      <= ST_CMD;
            fb_swapped <= 1'b1;
            cmd_tvalid <= 1'b0;
            cmd_tlast  <= 1'b0;
        end
        else
        begin
            case (state)
                ST_CMD:
                begin
                    if (swap_fb)
                    begin
                        cmd_tvalid <= 1'b1;
                        cmd_tlast  <= 1'b0;
                        fb_swapped <= 1'b0;
                        state      <= ST_ADDR;
                    end
                end
                ST_ADDR:
                begin
                    if (cmd_hs)
                    begin
                        cmd_tlast <= 1'b1;
                        state     <= ST_WAIT;
                    end
                end
                ST_WAIT:
                begin
                    // Engine holds the command now, the swap counts as done
                    if (cmd_hs)
                    begin
                        cmd_tvalid <= 1'b0;
                        cmd_tlast  <= 1'b0;
                        fb_swapped <= 1'b1;
                        state      <= ST_CMD;
                    end
                end
                default:
                begin
                    state <= ST_CMD;
                end
            endcase
        end
    end

    // Command word payload
    always_ff @(posedge aclk)
    begin
        if (state == ST_CMD && swap_fb)
        begin
            cmd_tdata.hdr.op         <= DMA_OP_MEM_TO_STREAM;
            cmd_tdata.hdr.mode       <= DMA_MODE_INCR;
            cmd_tdata.hdr.byte_count <= FRAME_BYTES;
        end
        else if (state == ST_ADDR && cmd_hs)
        begin
            cmd_tdata.addr <= fb_addr;
        end
    end

    // Command word and its position held until the engine takes it
    a_cmd_stable: assert property (@(posedge aclk) disable iff (!resetn)
        cmd_tvalid && !cmd_tready |=> cmd_tvalid && $stable(cmd_tdata) && $stable(cmd_tlast));

endmodule

/* verilog/dma_read_engine.sv */
/*
 * DMA read engine
 * Decodes a header plus address command, reads the frame from memory in
 * bounded INCR bursts with one burst in flight, and streams the data out
 */
`timescale 1ns/1ns

module dma_read_engine #(
    parameter int MAX_BURST_BEATS = 16
) (
    input  logic               aclk,
    input  logic               resetn,

    // Command stream
    input  logic               cmd_tvalid,
    output logic               cmd_tready,
    input  logic               cmd_tlast,
    input  dma_pkg::cmd_word_u cmd_tdata,

    // Memory read address channel
    output dma_pkg::mem_addr_t m_mem_axi_araddr,
    output logic [7:0]         m_mem_axi_arlen,
    output logic               m_mem_axi_arvalid,
    input  logic               m_mem_axi_arready,

    // Memory read data channel
    input  dma_pkg::mem_word_t m_mem_axi_rdata,
    input  logic               m_mem_axi_rlast,
    input  logic               m_mem_axi_rvalid,
    output logic               m_mem_axi_rready,

    // Read data stream
    output logic               rd_tvalid,
    input  logic               rd_tready,
    output logic               rd_tlast,
    output dma_pkg::mem_word_t rd_tdata
);
    import dma_pkg::*;

    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_AR   = 2'd1;
    localparam logic [1:0] ST_R    = 2'd2;
    localparam logic [1:0] ST_DONE = 2'd3;

    localparam int BURST_BYTES = MAX_BURST_BEATS * MEM_WORD_BYTES;

    logic [1:0]  state;
    logic        hdr_ok;
    logic [25:0] beats_left;
    mem_addr_t   run_addr;
    logic [8:0]  burst_beats;
    logic        cmd_hs;
    logic        ar_hs;
    logic        r_hs;
    logic        rd_hs;

    assign cmd_tready = (state == ST_IDLE);
    assign cmd_hs     = cmd_tvalid && cmd_tready;
    assign ar_hs      = m_mem_axi_arvalid && m_mem_axi_arready;
    assign r_hs       = m_mem_axi_rvalid && m_mem_axi_rready;
    assign rd_hs      = rd_tvalid && rd_tready;

    // Next burst is capped by the remaining beats
    assign burst_beats = (beats_left > 26'(MAX_BURST_BEATS)) ? 9'(MAX_BURST_BEATS)
                                                             : beats_left[8:0];

    // Address and length only move on the address handshake
    assign m_mem_axi_araddr = run_addr;
    assign m_mem_axi_arlen  = 8'(burst_beats - 9'd1);

    always_ff @(posedge aclk)
    begin
        if (!resetn)
        begin
            state             <= ST_IDLE;
            hdr_ok            <= 1'b0;
            beats_left        <= '0;
            m_mem_axi_arvalid <= 1'b0;
        end
        else
        begin
            case (state)
                ST_IDLE:
                begin
                    if (cmd_hs && !cmd_tlast)
                    begin
                        // Unsupported headers and empty frames are dropped
                        hdr_ok <= (cmd_tdata.hdr.op == DMA_OP_MEM_TO_STREAM)
                            && (cmd_tdata.hdr.mode == DMA_MODE_INCR)
                            && (cmd_tdata.hdr.byte_count >= 28'(MEM_WORD_BYTES));
                        beats_left <= 26'(cmd_tdata.hdr.byte_count / MEM_WORD_BYTES);
                    end
                    else if (cmd_hs)
                    begin
                        hdr_ok <= 1'b0;
                        if (hdr_ok)
                        begin
                            m_mem_axi_arvalid <= 1'b1;
                            state             <= ST_AR;
                        end
                    end
                end
                ST_AR:
                begin
                    if (ar_hs)
                    begin
                        m_mem_axi_arvalid <= 1'b0;
                        beats_left        <= beats_left - 26'(burst_beats);
                        state             <= ST_R;
                    end
                end
                ST_R:
                begin
                    if (r_hs && m_mem_axi_rlast)
                    begin
                        if (beats_left != '0)
                        begin
                            m_mem_axi_arvalid <= 1'b1;
                            state             <= ST_AR;
                        end
                        else
                        begin
                            state <= ST_DONE;
                        end
                    end
                end
                default:
                begin
                    // Wait until the last word has left the output register
                    if (rd_hs && rd_tlast)
                    begin
                        state <= ST_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge aclk)
    begin
        if (state == ST_IDLE && cmd_hs && cmd_tlast)
        begin
            run_addr <= cmd_tdata.addr;
        end
        else if (ar_hs)
        begin
            run_addr <= run_addr + mem_addr_t'(burst_beats) * MEM_WORD_BYTES;
        end
    end

    // Single output register between the read channel and the stream
    assign m_mem_axi_rready = !rd_tvalid || rd_tready;

    always_ff @(posedge aclk)
    begin
        if (!resetn)
        begin
            rd_tvalid <= 1'b0;
        end
        else if (r_hs)
        begin
            rd_tvalid <= 1'b1;
        end
        else if (rd_tready)
        begin
            rd_tvalid <= 1'b0;
        end
    end

    always_ff @(posedge aclk)
    begin
        if (r_hs)
        begin
            rd_tdata <= m_mem_axi_rdata;
            rd_tlast <= m_mem_axi_rlast && (beats_left == '0);
        end
    end

    a_whole_words: assert property (@(posedge aclk) disable iff (!resetn)
        cmd_hs && !cmd_tlast && cmd_tdata.hdr.op == DMA_OP_MEM_TO_STREAM
        |-> (cmd_tdata.hdr.byte_count % MEM_WORD_BYTES) == 0);

    // Burst aligned base keeps every burst inside one 4 KB page
    a_base_aligned: assert property (@(posedge aclk) disable iff (!resetn)
        cmd_hs && cmd_tlast && hdr_ok |-> (cmd_tdata.addr % BURST_BYTES) == 0);

    a_ar_stable: assert property (@(posedge aclk) disable iff (!resetn)
        m_mem_axi_arvalid && !m_mem_axi_arready
        |=> m_mem_axi_arvalid && $stable(m_mem_axi_araddr) && $stable(m_mem_axi_arlen));

endmodule

/* verilog/pixel_width_adapter.sv */
/*
 * Pixel width adapter
 * Splits each 32-bit framebuffer word into RGB565 pixels for the display,
 * low half first, with tlast on the final pixel of the frame
 */
`timescale 1ns/1ns

module pixel_width_adapter (
    input  logic               aclk,
    input  logic               resetn,

    // Word stream from the DMA engine
    input  logic               rd_tvalid,
    output logic               rd_tready,
    input  logic               rd_tlast,
    input  dma_pkg::mem_word_t rd_tdata,

    // Display pixel stream
    output logic               m_disp_axis_tvalid,
    input  logic               m_disp_axis_tready,
    output logic               m_disp_axis_tlast,
    output disp_pkg::pixel_t   m_disp_axis_tdata
);
    import dma_pkg::*;
    import disp_pkg::*;

    localparam int SEL_BITS = $clog2(PIXELS_PER_WORD);

    mem_word_t           word;
    logic                word_last;
    logic [SEL_BITS-1:0] sel;
    logic                last_pix;

    assign last_pix = (sel == SEL_BITS'(PIXELS_PER_WORD - 1));

    assign m_disp_axis_tdata = word[sel * PIXEL_BITS +: PIXEL_BITS];
    assign m_disp_axis_tlast = word_last && last_pix;

    // Next word only once the held word's last pixel leaves
    assign rd_tready = !m_disp_axis_tvalid || (m_disp_axis_tready && last_pix);

    always_ff @(posedge aclk)
    begin
        if (!resetn)
        begin
            m_disp_axis_tvalid <= 1'b0;
            sel                <= '0;
        end
        else if (rd_tvalid && rd_tready)
        begin
            m_disp_axis_tvalid <= 1'b1;
            sel                <= '0;
        end
        else if (m_disp_axis_tvalid && m_disp_axis_tready)
        begin
            if (last_pix)
                m_disp_axis_tvalid <= 1'b0;
            else
                sel <= sel + 1'b1;
        end
    end

    always_ff @(posedge aclk)
    begin
        if (rd_tvalid && rd_tready)
        begin
            word      <= rd_tdata;
            word_last <= rd_tlast;
        end
    end

    a_pixel_stable: assert property (@(posedge aclk) disable iff (!resetn)
        m_disp_axis_tvalid && !m_disp_axis_tready
        |=> m_disp_axis_tvalid && $stable(m_disp_axis_tdata) && $stable(m_disp_axis_tlast));

endmodule

/* verilog/fb_scanout_top.sv */
/*
 * Framebuffer scan-out top level
 * Command sequencer, DMA read engine and pixel width adapter between the
 * framebuffer memory read port and the display stream
 */
`timescale 1ns/1ns

module fb_scanout_top #(
    parameter int DISPLAY_SIZE_IN_BYTES = 320 * 480 * 2,
    parameter int MAX_BURST_BEATS       = 16
) (
    input  logic               aclk,
    input  logic               resetn,

    input  logic               swap_fb,
    input  dma_pkg::mem_addr_t fb_addr,
    output logic               fb_swapped,

    // Display stream
    output logic               m_disp_axis_tvalid,
    input  logic               m_disp_axis_tready,
    output logic               m_disp_axis_tlast,
    output disp_pkg::pixel_t   m_disp_axis_tdata,

    // Memory read port, 4-byte INCR bursts with ID zero
    output dma_pkg::mem_addr_t m_mem_axi_araddr,
    output logic [7:0]         m_mem_axi_arlen,
    output logic               m_mem_axi_arvalid,
    input  logic               m_mem_axi_arready,
    input  dma_pkg::mem_word_t m_mem_axi_rdata,
    input  logic               m_mem_axi_rlast,
    input  logic               m_mem_axi_rvalid,
    output logic               m_mem_axi_rready
);
    import dma_pkg::*;

    logic      cmd_tvalid;
    logic      cmd_tready;
    logic      cmd_tlast;
    cmd_word_u cmd_tdata;

    logic      rd_tvalid;
    logic      rd_tready;
    logic      rd_tlast;
    mem_word_t rd_tdata;

    fb_scanout_ctrl #(
        .DISPLAY_SIZE_IN_BYTES(DISPLAY_SIZE_IN_BYTES)
    ) ctrl0 (
        .aclk(aclk),
        .resetn(resetn),
        .swap_fb(swap_fb),
        .fb_addr(fb_addr),
        .fb_swapped(fb_swapped),
        .cmd_tvalid(cmd_tvalid),
        .cmd_tready(cmd_tready),
        .cmd_tlast(cmd_tlast),
        .cmd_tdata(cmd_tdata)
    );

    dma_read_engine #(
        .MAX_BURST_BEATS(MAX_BURST_BEATS)
    ) dma0 (
        .aclk(aclk),
        .resetn(resetn),
        .cmd_tvalid(cmd_tvalid),
        .cmd_tready(cmd_tready),
        .cmd_tlast(cmd_tlast),
        .cmd_tdata(cmd_tdata),
        .m_mem_axi_araddr(m_mem_axi_araddr),
        .m_mem_axi_arlen(m_mem_axi_arlen),
        .m_mem_axi_arvalid(m_mem_axi_arvalid),
        .m_mem_axi_arready(m_mem_axi_arready),
        .m_mem_axi_rdata(m_mem_axi_rdata),
        .m_mem_axi_rlast(m_mem_axi_rlast),
        .m_mem_axi_rvalid(m_mem_axi_rvalid),
        .m_mem_axi_rready(m_mem_axi_rready),
        .rd_tvalid(rd_tvalid),
        .rd_tready(rd_tready),
        .rd_tlast(rd_tlast),
        .rd_tdata(rd_tdata)
    );

    pixel_width_adapter adapter0 (
        .aclk(aclk),
        .resetn(resetn),
        .rd_tvalid(rd_tvalid),
        .rd_tready(rd_tready),
        .rd_tlast(rd_tlast),
        .rd_tdata(rd_tdata),
        .m_disp_axis_tvalid(m_disp_axis_tvalid),
        .m_disp_axis_tready(m_disp_axis_tready),
        .m_disp_axis_tlast(m_disp_axis_tlast),
        .m_disp_axis_tdata(m_disp_axis_tdata)
    );

endmodule

/* verif/tb_clock_gen.sv */
/*
 * Testbench clock and power-on reset generator
 */
`timescale 1ns/1ns

module tb_clock_gen #(
    parameter int PERIOD_NS    = 4,
    parameter int RESET_CYCLES = 16
) (
    output logic aclk,
    output logic por_resetn
);
    int count;

    initial
    begin
        aclk       = 1'b0;
        por_resetn = 1'b0;
        count      = 0;
    end

    always #(PERIOD_NS / 2) aclk = ~aclk;

    // Reset seen low on the first RESET_CYCLES rising edges
    always @(posedge aclk)
    begin
        count <= count + 1;
        if (count == RESET_CYCLES - 1)
            por_resetn <= 1'b1;
    end

endmodule

/* verif/axi_mem_responder.sv */
/*
 * AXI4 read memory model
 * Answers one read burst at a time with data derived from the byte
 * address, with a random arready delay and random gaps between beats
 */
`timescale 1ns/1ns

module axi_mem_responder #(
    parameter int SEED = 1
) (
    input  logic               aclk,
    input  logic               resetn,
    input  dma_pkg::mem_addr_t araddr,
    input  logic [7:0]         arlen,
    input  logic               arvalid,
    output logic               arready,
    output dma_pkg::mem_word_t rdata,
    output logic               rlast,
    output logic               rvalid,
    input  logic               rready
);
    import dma_pkg::*;

    integer    seed;
    logic      busy;
    mem_addr_t beat_addr;
    int        beats_left;

    // Framebuffer contents as a function of the byte address
    function automatic mem_word_t word_at(input mem_addr_t a);
        return (a ^ 32'h5A5A_0000) + (a >> 2);
    endfunction

    initial
    begin
        seed       = SEED;
        busy       = 1'b0;
        beat_addr  = '0;
        beats_left = 0;
        arready    = 1'b0;
        rvalid     = 1'b0;
        rlast      = 1'b0;
        rdata      = '0;
    end

    always @(posedge aclk)
    begin
        if (!resetn)
        begin
            busy    <= 1'b0;
            arready <= 1'b0;
            rvalid  <= 1'b0;
            rlast   <= 1'b0;
        end
        else if (!busy)
        begin
            if (arvalid && arready)
            begin
                arready    <= 1'b0;
                busy       <= 1'b1;
                beat_addr  <= araddr;
                beats_left <= int'(arlen) + 1;
            end
            else
            begin
                arready <= (($random(seed) & 3) == 0);
            end
        end
        else if (!rvalid || rready)
        begin
            // The beat on the bus, if any, is taken at this edge
            if (rvalid && rlast)
            begin
                rvalid <= 1'b0;
                rlast  <= 1'b0;
                busy   <= 1'b0;
            end
            else if (($random(seed) & 3) != 0)
            begin
                rvalid     <= 1'b1;
                rdata      <= word_at(beat_addr);
                rlast      <= (beats_left == 1);
                beat_addr  <= beat_addr + MEM_WORD_BYTES;
                beats_left <= beats_left - 1;
            end
            else
            begin
                rvalid <= 1'b0;
            end
        end
    end

endmodule

/* verif/fb_scanout_tb.sv */
/*
 * Framebuffer scan-out testbench
 * Random frames checked against a model of the framebuffer contents,
 * the burst plan, frame end and swap status, plus back-to-back swaps
 * and a reset in the middle of a frame
 */
`timescale 1ns/1ns

module fb_scanout_tb;
    import dma_pkg::*;
    import disp_pkg::*;

    localparam int SEED         = 34480;
    localparam int FRAME_BYTES  = 200;
    localparam int BURST_BEATS  = 16;
    localparam int RESET_CYCLES = 16;
    localparam int FRAME_BEATS  = FRAME_BYTES / MEM_WORD_BYTES;
    localparam int FRAME_PIXELS = FRAME_BEATS * PIXELS_PER_WORD;
    localparam int FRAME_BURSTS = (FRAME_BEATS + BURST_BEATS - 1) / BURST_BEATS;
    localparam int TIMEOUT      = 5000;

    logic       aclk;
    logic       por_resetn;
    logic       soft_resetn = 1'b1;
    logic       resetn;
    logic       swap_fb = 1'b0;
    mem_addr_t  fb_addr = '0;
    logic       fb_swapped;
    logic       m_disp_axis_tvalid;
    logic       m_disp_axis_tready = 1'b0;
    logic       m_disp_axis_tlast;
    pixel_t     m_disp_axis_tdata;
    mem_addr_t  m_mem_axi_araddr;
    logic [7:0] m_mem_axi_arlen;
    logic       m_mem_axi_arvalid;
    logic       m_mem_axi_arready;
    mem_word_t  m_mem_axi_rdata;
    logic       m_mem_axi_rlast;
    logic       m_mem_axi_rvalid;
    logic       m_mem_axi_rready;

    integer     seed = SEED;
    logic       full_speed = 1'b0;
    int         cycle = 0;
    int         errors = 0;
    int         tests = 0;
    int         tests_failed = 0;

    // Observed traffic
    pixel_t     pix_q[$];
    logic       last_q[$];
    logic       swapped_q[$];
    int         end_cyc_q[$];
    mem_addr_t  ar_addr_q[$];
    logic [7:0] ar_len_q[$];
    int         ar_cyc_q[$];

    assign resetn = por_resetn && soft_resetn;

    tb_clock_gen #(
        .PERIOD_NS(4),
        .RESET_CYCLES(RESET_CYCLES)
    ) clk0 (
        .aclk(aclk),
        .por_resetn(por_resetn)
    );

    axi_mem_responder #(
        .SEED(SEED)
    ) mem0 (
        .aclk(aclk),
        .resetn(resetn),
        .araddr(m_mem_axi_araddr),
        .arlen(m_mem_axi_arlen),
        .arvalid(m_mem_axi_arvalid),
        .arready(m_mem_axi_arready),
        .rdata(m_mem_axi_rdata),
        .rlast(m_mem_axi_rlast),
        .rvalid(m_mem_axi_rvalid),
        .rready(m_mem_axi_rready)
    );

    fb_scanout_top #(
        .DISPLAY_SIZE_IN_BYTES(FRAME_BYTES),
        .MAX_BURST_BEATS(BURST_BEATS)
    ) dut0 (
        .aclk(aclk),
        .resetn(resetn),
        .swap_fb(swap_fb),
        .fb_addr(fb_addr),
        .fb_swapped(fb_swapped),
        .m_disp_axis_tvalid(m_disp_axis_tvalid),
        .m_disp_axis_tready(m_disp_axis_tready),
        .m_disp_axis_tlast(m_disp_axis_tlast),
        .m_disp_axis_tdata(m_disp_axis_tdata),
        .m_mem_axi_araddr(m_mem_axi_araddr),
        .m_mem_axi_arlen(m_mem_axi_arlen),
        .m_mem_axi_arvalid(m_mem_axi_arvalid),
        .m_mem_axi_arready(m_mem_axi_arready),
        .m_mem_axi_rdata(m_mem_axi_rdata),
        .m_mem_axi_rlast(m_mem_axi_rlast),
        .m_mem_axi_rvalid(m_mem_axi_rvalid),
        .m_mem_axi_rready(m_mem_axi_rready)
    );

    // Handshake monitor and display back-pressure
    always @(posedge aclk)
    begin
        cycle <= cycle + 1;
        if (m_disp_axis_tvalid && m_disp_axis_tready)
        begin
            pix_q.push_back(m_disp_axis_tdata);
            last_q.push_back(m_disp_axis_tlast);
            if (m_disp_axis_tlast)
            begin
                swapped_q.push_back(fb_swapped);
                end_cyc_q.push_back(cycle);
            end
        end
        if (m_mem_axi_arvalid && m_mem_axi_arready)
        begin
            ar_addr_q.push_back(m_mem_axi_araddr);
            ar_len_q.push_back(m_mem_axi_arlen);
            ar_cyc_q.push_back(cycle);
        end
        m_disp_axis_tready <= full_speed || (($random(seed) & 3) != 0);
    end

    // Framebuffer word at a byte address
    function automatic mem_word_t model_word(input mem_addr_t a);
        return (a ^ 32'h5A5A_0000) + (a >> 2);
    endfunction

    // Burst aligned base kept clear of the top of the address space
    function automatic mem_addr_t random_base();
        return mem_addr_t'($random(seed)) & 32'h7FFF_FFC0;
    endfunction

    task automatic compare_pixel(input int idx, input pixel_t got, input pixel_t exp);
        if (got !== exp)
        begin
            $display("[ERROR] %0t ns: pixel %0d is %h, expected %h", $time, idx, got, exp);
            errors++;
        end
    endtask

    task automatic compare_burst(input int idx, input mem_addr_t addr, input logic [7:0] len,
                                 input mem_addr_t exp_addr, input logic [7:0] exp_len);
        if (addr !== exp_addr || len !== exp_len)
        begin
            $display("[ERROR] %0t ns: burst %0d at %h len %0d, expected %h len %0d",
                     $time, idx, addr, len, exp_addr, exp_len);
            errors++;
        end
    endtask

    task automatic compare_flag(input string what, input logic got, input logic exp);
        if (got !== exp)
        begin
            $display("[ERROR] %0t ns: %s is %b, expected %b", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic stop_on_timeout(input string what);
        $display("timeout waiting for %s at %0t ns", what, $time);
        $display("Simulation finished: FAIL");
        $finish;
    endtask

    task automatic wait_swapped();
        int n;
        n = 0;
        while (fb_swapped !== 1'b1)
        begin
            @(posedge aclk);
            n++;
            if (n > TIMEOUT)
                stop_on_timeout("fb_swapped to rise");
        end
    endtask

    task automatic wait_frames(input int target);
        int n;
        n = 0;
        while (end_cyc_q.size() < target)
        begin
            @(posedge aclk);
            n++;
            if (n > TIMEOUT)
                stop_on_timeout("the last pixel of a frame");
        end
    endtask

    task automatic wait_pixels(input int target);
        int n;
        n = 0;
        while (pix_q.size() < target)
        begin
            @(posedge aclk);
            n++;
            if (n > TIMEOUT)
                stop_on_timeout("display pixels");
        end
    endtask

    task automatic clear_queues();
        pix_q.delete();
        last_q.delete();
        swapped_q.delete();
        end_cyc_q.delete();
        ar_addr_q.delete();
        ar_len_q.delete();
        ar_cyc_q.delete();
    endtask

    // One-cycle swap request while the sequencer is idle
    task automatic start_frame(input mem_addr_t addr);
        @(posedge aclk);
        fb_addr <= addr;
        swap_fb <= 1'b1;
        @(posedge aclk);
        swap_fb <= 1'b0;
        @(posedge aclk);
    endtask

    task automatic check_pixels(input mem_addr_t base, input int first);
        mem_word_t w;
        if (pix_q.size() < first + FRAME_PIXELS)
        begin
            $display("frame at %h delivered only %0d pixels", base, pix_q.size() - first);
            errors++;
            return;
        end
        for (int i = 0; i < FRAME_PIXELS; i++)
        begin
            w = model_word(base + MEM_WORD_BYTES * (i / PIXELS_PER_WORD));
            compare_pixel(i, pix_q[first + i], (i % 2 == 0) ? w[15:0] : w[31:16]);
        end
    endtask

    task automatic check_tlast(input int first);
        for (int i = 0; i < FRAME_PIXELS && first + i < last_q.size(); i++)
            compare_flag($sformatf("tlast on pixel %0d", i), last_q[first + i],
                         i == FRAME_PIXELS - 1);
    endtask

    task automatic check_bursts(input mem_addr_t base, input int first);
        mem_addr_t a;
        int left;
        int n;
        int k;
        a = base;
        left = FRAME_BEATS;
        k = first;
        while (left > 0)
        begin
            n = (left > BURST_BEATS) ? BURST_BEATS : left;
            if (k >= ar_addr_q.size())
            begin
                $display("read burst %0d never appeared on the address channel", k);
                errors++;
                return;
            end
            compare_burst(k, ar_addr_q[k], ar_len_q[k], a, 8'(n - 1));
            a = a + n * MEM_WORD_BYTES;
            left = left - n;
            k++;
        end
    endtask

    task automatic end_test(input string name, input int new_errors);
        tests++;
        if (new_errors == 0)
        begin
            $display("test %0d %s: passed", tests, name);
        end
        else
        begin
            tests_failed++;
            $display("test %0d %s: failed with %0d errors", tests, name, new_errors);
        end
    endtask

    initial
    begin
        mem_addr_t base_a;
        mem_addr_t base_b;
        int e0;
        int swap_errors;

        repeat (RESET_CYCLES + 2) @(posedge aclk);

        // Single frame covering content, frame end, bursts and fb_swapped
        base_a = random_base();
        e0 = errors;
        compare_flag("fb_swapped after reset", fb_swapped, 1'b1);
        start_frame(base_a);
        compare_flag("fb_swapped after swap_fb", fb_swapped, 1'b0);
        wait_frames(1);
        compare_flag("fb_swapped at last pixel", swapped_q[0], 1'b1);
        swap_errors = errors - e0;
        e0 = errors;
        check_pixels(base_a, 0);
        end_test("pixel content", errors - e0);
        e0 = errors;
        check_tlast(0);
        end_test("frame end", errors - e0);
        e0 = errors;
        check_bursts(base_a, 0);
        end_test("burst plan", errors - e0);
        end_test("fb_swapped", swap_errors);

        // Second swap while the first frame is still streaming
        clear_queues();
        base_a = random_base();
        base_b = random_base();
        full_speed <= 1'b1;
        e0 = errors;
        start_frame(base_a);
        wait_swapped();
        start_frame(base_b);
        wait_frames(2);
        check_pixels(base_a, 0);
        check_pixels(base_b, FRAME_PIXELS);
        check_tlast(0);
        check_tlast(FRAME_PIXELS);
        check_bursts(base_a, 0);
        check_bursts(base_b, FRAME_BURSTS);
        compare_flag("second frame starts after first frame end",
                     ar_cyc_q.size() > FRAME_BURSTS && ar_cyc_q[FRAME_BURSTS] > end_cyc_q[0],
                     1'b1);
        end_test("back-to-back swaps", errors - e0);
        full_speed <= 1'b0;

        // Reset pulse in the middle of a frame
        clear_queues();
        e0 = errors;
        start_frame(random_base());
        wait_pixels(30);
        soft_resetn <= 1'b0;
        @(posedge aclk);
        @(posedge aclk);
        soft_resetn <= 1'b1;
        compare_flag("display tvalid after reset", m_disp_axis_tvalid, 1'b0);
        compare_flag("arvalid after reset", m_mem_axi_arvalid, 1'b0);
        compare_flag("rready after reset", m_mem_axi_rready, 1'b1);
        compare_flag("command tvalid after reset", dut0.cmd_tvalid, 1'b0);
        compare_flag("read stream tvalid after reset", dut0.rd_tvalid, 1'b0);
        compare_flag("fb_swapped after reset", fb_swapped, 1'b1);
        @(posedge aclk);
        clear_queues();
        base_b = random_base();
        start_frame(base_b);
        wait_frames(1);
        check_pixels(base_b, 0);
        check_tlast(0);
        check_bursts(base_b, 0);
        end_test("reset mid-frame", errors - e0);

        $display("%0d tests run, %0d failed, %0d errors", tests, tests_failed, errors);
        if (errors == 0 && tests_failed == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

/* sim.f */
verilog/dma_pkg.sv
verilog/disp_pkg.sv
verilog/fb_scanout_ctrl.sv
verilog/dma_read_engine.sv
verilog/pixel_width_adapter.sv
verilog/fb_scanout_top.sv
verif/tb_clock_gen.sv
verif/axi_mem_responder.sv
verif/fb_scanout_tb.sv
